// File: Makefile
# Verilator flow for the IPv4 header rewriter

VERILATOR ?= verilator
TOP       ?= ipv4_rewrite_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= *** FAILED ***
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -F -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -F -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/csum_delta_acc.sv
/* Incremental IPv4 checksum update after RFC 1624 eqn 3
   Sums ~m + m' of changed words and folds it into the old checksum */

`default_nettype none

module csum_delta_acc (
    input  wire logic                            clk,
    input  wire logic                            rst_n_i,
    input  wire logic                            clear_i,
    input  wire logic                            add_i,
    input  wire logic [ipv4_rw_pkg::WORD_W-1:0]  old_word_i,
    input  wire logic [ipv4_rw_pkg::WORD_W-1:0]  new_word_i,
    input  wire logic [ipv4_rw_pkg::WORD_W-1:0]  old_csum_i,
    output logic      [ipv4_rw_pkg::WORD_W-1:0]  new_csum_o
);

    import ipv4_rw_pkg::*;

    logic [WORD_W-1:0] acc;
    logic [WORD_W-1:0] base;
    logic [WORD_W-1:0] delta;

    // Ones-complement add, carry wrapped back in
    function automatic logic [WORD_W-1:0] oc_add(input logic [WORD_W-1:0] a,
                                                  input logic [WORD_W-1:0] b);
        logic [WORD_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[WORD_W-1:0] + WORD_W'(sum[WORD_W]);
    endfunction

    assign base  = clear_i ? '0 : acc;
    assign delta = oc_add(~old_word_i, new_word_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            acc <= '0;
        end else if (add_i) begin
            acc <= oc_add(base, delta);
        end else if (clear_i) begin
            acc <= '0;
        end
    end

    // HC' = ~(~HC + sum of (~m + m'))
    assign new_csum_o = ~oc_add(~old_csum_i, acc);

endmodule

`default_nettype wire

// File: design/field_rewriter.sv
/* IPv4 field rewriter with output credit counter
   Rewrites TOS, TTL and checksum of header words and registers the output stream */

`default_nettype none

module field_rewriter (
    input  wire logic                            clk,
    input  wire logic                            rst_n_i,
    word_stream_if.sink                          rd,
    input  wire ipv4_rw_pkg::fld_sel_e           fld_sel_i,
    input  wire logic                            acc_clear_i,
    input  wire logic                            remark_en_i,
    input  wire logic [7:0]                      new_tos_i,
    input  wire logic                            out_credit_i,
    output logic                                 out_valid_o,
    output logic      [ipv4_rw_pkg::WORD_W-1:0]  out_data_o,
    output logic                                 out_last_o,
    output logic                                 pop_o
);

    import ipv4_rw_pkg::*;

    logic [CRED_W-1:0] cred_cnt;
    logic              have_credit;
    logic              acc_add;
    logic [WORD_W-1:0] new_word;
    logic [WORD_W-1:0] new_csum;
    logic [7:0]        ttl;

    //////////////////////////////////////////////////////////////////////
    // Pop control and downstream credits
    //////////////////////////////////////////////////////////////////////

    assign have_credit = (cred_cnt != '0);
    assign rd.pop      = have_credit;
    assign pop_o       = rd.valid && have_credit;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cred_cnt <= CRED_W'(OUT_CREDITS);
        end else begin
            // Spend and return can coincide and cancel out
            case ({pop_o, out_credit_i})
                2'b10:   cred_cnt <= cred_cnt - 1'b1;
                2'b01:   cred_cnt <= cred_cnt + 1'b1;
                default: cred_cnt <= cred_cnt;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Field substitution
    //////////////////////////////////////////////////////////////////////

    assign ttl = rd.data[WORD_W-1:8];

    always_comb begin
        new_word = rd.data;
        case (fld_sel_i)
            FLD_TOS: begin
                if (remark_en_i) begin
                    new_word = {rd.data[WORD_W-1:8], new_tos_i};
                end
            end
            FLD_TTL: begin
                // Expired TTL is left at zero
                if (ttl != 8'd0) begin
                    new_word = {ttl - 8'd1, rd.data[7:0]};
                end
            end
            FLD_CSUM: new_word = new_csum;
            default:  new_word = rd.data;
        endcase
    end

    assign acc_add = pop_o && ((fld_sel_i == FLD_TOS) || (fld_sel_i == FLD_TTL));

    csum_delta_acc u_csum (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .clear_i    (acc_clear_i),
        .add_i      (acc_add),
        .old_word_i (rd.data),
        .new_word_i (new_word),
        .old_csum_i (rd.data),
        .new_csum_o (new_csum)
    );

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= pop_o;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            out_data_o <= new_word;
            out_last_o <= rd.last;
        end
    end

endmodule

`default_nettype wire

// File: design/hdr_word_counter.sv
/* Position of the head word within its packet
   Advances on each pop, saturates, and restarts after a last word */

`default_nettype none

module hdr_word_counter (
    input  wire logic                           clk,
    input  wire logic                           rst_n_i,
    input  wire logic                           pop_i,
    input  wire logic                           last_i,
    output logic [ipv4_rw_pkg::CNT_W-1:0]       word_idx_o
);

    import ipv4_rw_pkg::*;

    logic at_max;

    // Only positions below HDR_WORDS are decoded, so holding at the top is harmless
    assign at_max = (word_idx_o == {CNT_W{1'b1}});

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            word_idx_o <= '0;
        end else if (pop_i) begin
            if (last_i) begin
                // Next word opens a new packet
                word_idx_o <= '0;
            end else if (!at_max) begin
                word_idx_o <= word_idx_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/ipv4_rewrite_top.sv
/* IPv4 header rewriter top level
   Input FIFO, position counter, phase FSM and field rewriter on credit flow control */

`default_nettype none

module ipv4_rewrite_top (
    input  wire logic                            clk,
    input  wire logic                            rst_n_i,
    // Upstream word stream
    input  wire logic                            in_valid_i,
    input  wire logic [ipv4_rw_pkg::WORD_W-1:0]  in_data_i,
    input  wire logic                            in_last_i,
    output logic                                 in_credit_o,
    // Downstream word stream
    output logic                                 out_valid_o,
    output logic      [ipv4_rw_pkg::WORD_W-1:0]  out_data_o,
    output logic                                 out_last_o,
    input  wire logic                            out_credit_i,
    // Configuration
    input  wire logic                            remark_en_i,
    input  wire logic [7:0]                      new_tos_i
);

    import ipv4_rw_pkg::*;

    logic             pop;
    logic [CNT_W-1:0] word_idx;
    fld_sel_e         fld_sel;
    logic             acc_clear;

    word_stream_if u_link ();

    word_fifo u_fifo (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_last_i   (in_last_i),
        .in_credit_o (in_credit_o),
        .rd          (u_link)
    );

    hdr_word_counter u_cnt (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .pop_i      (pop),
        .last_i     (u_link.last),
        .word_idx_o (word_idx)
    );

    rewrite_fsm u_fsm (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .pop_i       (pop),
        .last_i      (u_link.last),
        .word_idx_i  (word_idx),
        .fld_sel_o   (fld_sel),
        .acc_clear_o (acc_clear)
    );

    field_rewriter u_rw (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .rd           (u_link),
        .fld_sel_i    (fld_sel),
        .acc_clear_i  (acc_clear),
        .remark_en_i  (remark_en_i),
        .new_tos_i    (new_tos_i),
        .out_credit_i (out_credit_i),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_last_o   (out_last_o),
        .pop_o        (pop)
    );

endmodule

`default_nettype wire

// File: design/ipv4_rw_pkg.sv
/* IPv4 header rewriter shared definitions
   Stream geometry, header field positions, credit depths and FSM types */

`default_nettype none

package ipv4_rw_pkg;

    //////////////////////////////////////////////////////////////////////
    // Stream and header geometry
    //////////////////////////////////////////////////////////////////////

    localparam int WORD_W    = 16;
    localparam int HDR_WORDS = 10;
    localparam int CNT_W     = 4;

    // Word positions inside a 20-byte header without options
    localparam int TOS_WORD  = 0;
    localparam int TTL_WORD  = 4;
    localparam int CSUM_WORD = 5;

    //////////////////////////////////////////////////////////////////////
    // Credit flow control
    //////////////////////////////////////////////////////////////////////

    localparam int IN_CREDITS  = 4;
    localparam int OUT_CREDITS = 4;

    // Derived widths for FIFO pointers, FIFO fill and output credit count
    localparam int FIFO_AW = $clog2(IN_CREDITS);
    localparam int FIFO_CW = $clog2(IN_CREDITS + 1);
    localparam int CRED_W  = $clog2(OUT_CREDITS + 1);

    // Rewrite phase of the current packet
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_PAYLOAD
    } rw_state_e;

    // Role of the word at the head of the FIFO
    typedef enum logic [1:0] {
        FLD_PASS,
        FLD_TOS,
        FLD_TTL,
        FLD_CSUM
    } fld_sel_e;

endpackage

`default_nettype wire

// File: design/rewrite_fsm.sv
/* Packet phase FSM for the header rewriter
   Follows header and payload phases and assigns the field role of the head word */

`default_nettype none

module rewrite_fsm (
    input  wire logic                           clk,
    input  wire logic                           rst_n_i,
    input  wire logic                           pop_i,
    input  wire logic                           last_i,
    input  wire logic [ipv4_rw_pkg::CNT_W-1:0]  word_idx_i,
    output ipv4_rw_pkg::fld_sel_e               fld_sel_o,
    output logic                                acc_clear_o
);

    import ipv4_rw_pkg::*;

    rw_state_e state;

    //////////////////////////////////////////////////////////////////////
    // Phase tracking
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= ST_IDLE;
        end else if (pop_i) begin
            if (last_i) begin
                // Short packets end here as well
                state <= ST_IDLE;
            end else begin
                case (state)
                    ST_IDLE:    state <= ST_HDR;
                    ST_HDR: begin
                        if (word_idx_i == CNT_W'(HDR_WORDS - 1)) begin
                            state <= ST_PAYLOAD;
                        end
                    end
                    ST_PAYLOAD: state <= ST_PAYLOAD;
                    default:    state <= ST_IDLE;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Field role decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        fld_sel_o = FLD_PASS;
        if (state != ST_PAYLOAD) begin
            case (word_idx_i)
                CNT_W'(TOS_WORD):  fld_sel_o = FLD_TOS;
                CNT_W'(TTL_WORD):  fld_sel_o = FLD_TTL;
                CNT_W'(CSUM_WORD): fld_sel_o = FLD_CSUM;
                default:           fld_sel_o = FLD_PASS;
            endcase
        end
    end

    // Fresh delta for every packet, taken with its first word
    assign acc_clear_o = pop_i && (word_idx_i == '0);

endmodule

`default_nettype wire

// File: design/word_fifo.sv
/* Input word FIFO sized to the upstream credit grant
   Stores data with its last flag and returns one credit per popped word */

`default_nettype none

module word_fifo (
    input  wire logic                            clk,
    input  wire logic                            rst_n_i,
    input  wire logic                            in_valid_i,
    input  wire logic [ipv4_rw_pkg::WORD_W-1:0]  in_data_i,
    input  wire logic                            in_last_i,
    output logic                                 in_credit_o,
    word_stream_if.source                        rd
);

    import ipv4_rw_pkg::*;

    // Each entry holds {last, data}
    logic [WORD_W:0]  mem [IN_CREDITS];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_CW-1:0] count;
    logic               full;
    logic               push;
    logic               pop;

    assign full = (count == FIFO_CW'(IN_CREDITS));
    // Upstream only sends while holding a credit, so a full write is a protocol error
    assign push = in_valid_i && !full;
    assign pop  = rd.valid && rd.pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {in_last_i, in_data_i};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            in_credit_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == FIFO_AW'(IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == FIFO_AW'(IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Slot freed, hand the credit back
            in_credit_o <= pop;
        end
    end

    assign rd.valid = (count != '0);
    assign rd.data  = mem[rd_ptr][WORD_W-1:0];
    assign rd.last  = mem[rd_ptr][WORD_W];

endmodule

`default_nettype wire

// File: design/word_stream_if.sv
/* Word link from the input FIFO to the field rewriter
   Transfer happens on every edge where valid and pop are both high */

`default_nettype none

interface word_stream_if;

    import ipv4_rw_pkg::*;

    logic              valid;
    logic [WORD_W-1:0] data;
    logic              last;
    logic              pop;

    // FIFO side
    modport source (
        output valid, data, last,
        input  pop
    );

    // Rewriter side
    modport sink (
        input  valid, data, last,
        output pop
    );

endinterface

`default_nettype wire

// File: sim.f
design/ipv4_rw_pkg.sv
design/word_stream_if.sv
design/word_fifo.sv
design/hdr_word_counter.sv
design/rewrite_fsm.sv
design/csum_delta_acc.sv
design/field_rewriter.sv
design/ipv4_rewrite_top.sv
testbench/ipv4_rewrite_props.sv
testbench/ipv4_rewrite_tb.sv

// File: testbench/ipv4_rewrite_props.sv
/* Bound checks for the output credit counter and the input FIFO
   Covers credit limits, FIFO overflow and register state under reset */

`default_nettype none

module ipv4_rewrite_props (
    input wire logic                            clk,
    input wire logic                            rst_n_i,
    input wire logic                            pulse_i,
    input wire logic                            cred_chk_i,
    input wire logic [ipv4_rw_pkg::CRED_W-1:0]  cred_cnt_i,
    input wire logic                            wr_req_i,
    input wire logic                            full_i
);

    import ipv4_rw_pkg::*;

    // Registered word comes from a pop taken with a credit in hand
    a_send_needs_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
        cred_chk_i && pulse_i |-> $past(cred_cnt_i) != '0)
        else $error("output word sent with no downstream credit");

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        cred_chk_i |-> cred_cnt_i <= CRED_W'(OUT_CREDITS))
        else $error("downstream credit count above its grant");

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_req_i |-> !full_i)
        else $error("input FIFO written while full");

    // Sync reset clears the pulse one edge later
    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n_i |=> !pulse_i)
        else $error("output pulse high during reset");

endmodule

bind field_rewriter ipv4_rewrite_props u_props (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .pulse_i    (out_valid_o),
    .cred_chk_i (1'b1),
    .cred_cnt_i (cred_cnt),
    .wr_req_i   (1'b0),
    .full_i     (1'b0)
);

bind word_fifo ipv4_rewrite_props u_props (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .pulse_i    (in_credit_o),
    .cred_chk_i (1'b0),
    .cred_cnt_i ('0),
    .wr_req_i   (in_valid_i),
    .full_i     (full)
);

`default_nettype wire

// File: testbench/ipv4_rewrite_tb.sv
/* Testbench for the IPv4 header rewriter
   Directed and random packets with credit emulation on both stream sides */

`default_nettype none

module ipv4_rewrite_tb;

    import ipv4_rw_pkg::*;

    localparam int WAIT_LIMIT = 5000;

    logic              clk = 1'b0;
    logic              rst_n_i;
    logic              in_valid_i;
    logic [WORD_W-1:0] in_data_i;
    logic              in_last_i;
    logic              in_credit_o;
    logic              out_valid_o;
    logic [WORD_W-1:0] out_data_o;
    logic              out_last_o;
    logic              out_credit_i = 1'b0;
    logic              remark_en_i;
    logic [7:0]        new_tos_i;

    // Stimulus and expected words as {last, data}
    logic [WORD_W:0] tx_q [$];
    logic [WORD_W:0] exp_q [$];
    int exp_total  = 0;
    int words_sent = 0;
    int cred_ret   = 0;
    int rx_count   = 0;
    int cred_given = 0;
    int cred_rate;
    bit cred_hold;

    ipv4_rewrite_top dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_data_i),
        .in_last_i    (in_last_i),
        .in_credit_o  (in_credit_o),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_last_o   (out_last_o),
        .out_credit_i (out_credit_i),
        .remark_en_i  (remark_en_i),
        .new_tos_i    (new_tos_i)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERR time %0t %s expected 0x%0h actual 0x%0h",
                                $time, name, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Credit emulation and output monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n_i) begin
            cred_ret <= 0;
        end else if (in_credit_o) begin
            cred_ret <= cred_ret + 1;
        end
    end

    // Downstream hands back one credit per consumed word, at a random rate
    always @(posedge clk) begin
        if (!rst_n_i) begin
            out_credit_i <= 1'b0;
            cred_given   <= 0;
        end else if (!cred_hold && (rx_count > cred_given)
                     && ($urandom_range(99) < cred_rate)) begin
            out_credit_i <= 1'b1;
            cred_given   <= cred_given + 1;
        end else begin
            out_credit_i <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst_n_i && out_valid_o) begin
            if (rx_count >= exp_q.size()) begin
                abort_run("output word arrived with no word expected");
            end
            if (rx_count - cred_given >= OUT_CREDITS) begin
                abort_run("more output words in flight than downstream credits");
            end
            check_eq("out_data_o", 32'(exp_q[rx_count][WORD_W-1:0]), 32'(out_data_o));
            check_eq("out_last_o", 32'(exp_q[rx_count][WORD_W]), 32'(out_last_o));
            rx_count <= rx_count + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Full header checksum, checksum field taken as zero
    function automatic logic [WORD_W-1:0] header_checksum(input logic [WORD_W-1:0] h [HDR_WORDS]);
        logic [31:0] sum;
        int i;
        sum = '0;
        for (i = 0; i < HDR_WORDS; i++) begin
            if (i != CSUM_WORD) begin
                sum = sum + 32'(h[i]);
            end
        end
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        return ~sum[15:0];
    endfunction

    task automatic make_header(output logic [WORD_W-1:0] h [HDR_WORDS], input logic [7:0] tos,
                               input logic [7:0] ttl, input logic [7:0] proto);
        int i;
        h[0] = {8'h45, tos};
        h[1] = 16'd20 + 16'($urandom_range(0, 1400));
        h[2] = 16'($urandom);
        h[3] = 16'h4000;
        h[4] = {ttl, proto};
        for (i = CSUM_WORD + 1; i < HDR_WORDS; i++) begin
            h[i] = 16'($urandom);
        end
        h[CSUM_WORD] = header_checksum(h);
    endtask

    // Queue a packet of len words and its rewritten image
    task automatic stage_packet(input logic [WORD_W-1:0] h [HDR_WORDS], input int len,
                                input bit remark, input logic [7:0] tos);
        logic [WORD_W-1:0] r [HDR_WORDS];
        logic [WORD_W-1:0] w;
        logic [WORD_W-1:0] e;
        int i;
        r = h;
        if (remark) begin
            r[TOS_WORD][7:0] = tos;
        end
        if (r[TTL_WORD][15:8] != 8'd0) begin
            r[TTL_WORD][15:8] = r[TTL_WORD][15:8] - 8'd1;
        end
        r[CSUM_WORD] = header_checksum(r);
        for (i = 0; i < len; i++) begin
            if (i < HDR_WORDS) begin
                w = h[i];
                e = r[i];
            end else begin
                w = 16'($urandom);
                e = w;
            end
            tx_q.push_back({i == len - 1, w});
            exp_q.push_back({i == len - 1, e});
        end
        exp_total = exp_total + len;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stream drivers
    //////////////////////////////////////////////////////////////////////

    task automatic send_staged(input int gap_pct);
        logic [WORD_W:0] w;
        int waited;
        while (tx_q.size() != 0) begin
            @(posedge clk);
            waited = 0;
            while ((IN_CREDITS + cred_ret - words_sent <= 0)
                   || ($urandom_range(99) < gap_pct)) begin
                in_valid_i <= 1'b0;
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("timed out waiting for an upstream credit");
                end
                @(posedge clk);
            end
            w = tx_q.pop_front();
            in_valid_i <= 1'b1;
            in_data_i  <= w[WORD_W-1:0];
            in_last_i  <= w[WORD_W];
            words_sent <= words_sent + 1;
        end
        @(posedge clk);
        in_valid_i <= 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        @(posedge clk);
        while (rx_count != exp_total) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("timed out waiting for the output stream to drain");
            end
            @(posedge clk);
        end
        check_eq("input credits returned", words_sent, cred_ret);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic ttl_decrement();
        logic [WORD_W-1:0] h [HDR_WORDS];
        h = '{16'h4500, 16'h0073, 16'h0000, 16'h4000, 16'h4011,
              16'hb861, 16'hc0a8, 16'h0001, 16'hc0a8, 16'h00c7};
        check_eq("reference checksum", 32'h0000b861, 32'(header_checksum(h)));
        stage_packet(h, 13, 1'b0, 8'h00);
        send_staged(0);
        wait_drained();
    endtask

    task automatic tos_remark();
        logic [WORD_W-1:0] h [HDR_WORDS];
        make_header(h, 8'h10, 8'd128, 8'd6);
        remark_en_i <= 1'b1;
        new_tos_i   <= 8'hb8;
        stage_packet(h, 12, 1'b1, 8'hb8);
        send_staged(0);
        wait_drained();
        remark_en_i <= 1'b0;
        stage_packet(h, 12, 1'b0, 8'hb8);
        send_staged(0);
        wait_drained();
    endtask

    task automatic ttl_zero();
        logic [WORD_W-1:0] h [HDR_WORDS];
        make_header(h, 8'h28, 8'd0, 8'd1);
        stage_packet(h, HDR_WORDS, 1'b0, 8'h00);
        send_staged(0);
        wait_drained();
    endtask

    task automatic random_stream();
        logic [WORD_W-1:0] h [HDR_WORDS];
        logic [7:0]        ttl;
        int n;
        remark_en_i <= 1'b1;
        new_tos_i   <= 8'h2e;
        cred_rate   <= 35;
        for (n = 0; n < 20; n++) begin
            ttl = ($urandom_range(0, 4) == 0) ? 8'd0 : 8'($urandom);
            make_header(h, 8'($urandom), ttl, 8'($urandom));
            stage_packet(h, $urandom_range(1, 18), 1'b1, 8'h2e);
        end
        send_staged(25);
        wait_drained();
        cred_rate <= 100;
    endtask

    task automatic credit_accounting();
        logic [WORD_W-1:0] h [HDR_WORDS];
        int waited;
        remark_en_i <= 1'b0;
        cred_hold   <= 1'b1;
        make_header(h, 8'h00, 8'd33, 8'd17);
        stage_packet(h, 14, 1'b0, 8'h00);
        fork
            send_staged(0);
            begin
                waited = 0;
                @(posedge clk);
                // Upstream runs dry once the FIFO backs up behind the held credits
                while (IN_CREDITS + cred_ret - words_sent != 0) begin
                    waited++;
                    if (waited > WAIT_LIMIT) begin
                        abort_run("timed out waiting for the stream to stall");
                    end
                    @(posedge clk);
                end
                repeat (20) @(posedge clk);
                check_eq("words in flight", OUT_CREDITS, rx_count - cred_given);
                check_eq("upstream credits left", 0, IN_CREDITS + cred_ret - words_sent);
                cred_hold <= 1'b0;
            end
        join
        wait_drained();
    endtask

    initial begin
        void'($urandom(78));
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        in_last_i   = 1'b0;
        remark_en_i = 1'b0;
        new_tos_i   = 8'h00;
        cred_hold   = 1'b0;
        cred_rate   = 100;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        ttl_decrement();
        tos_remark();
        ttl_zero();
        random_stream();
        credit_accounting();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
